// File: design/baudGen.sv
////////////////////
// Baud divider
// 16x sample tick and bit tick
////////////////////
`timescale 1ns/1ps

module baudGen (
  input  logic                      clk,
  input  logic                      nReset,
  input  logic [uartPkg::RateW-1:0] rate,
  output logic                      sampleTick,
  output logic                      bitTick
);
  localparam int SubW = $clog2(uartPkg::Oversample);

  logic [uartPkg::RateW-1:0] div, reload, sampleCnt, rateQ;
  logic [SubW-1:0] subCnt;
  logic rateChg;

  assign div = rate / uartPkg::RateW'(uartPkg::Oversample); // clocks per sample
  assign reload = (div == '0) ? '0 : div - 1'b1;  // tiny rates tick every clock
  assign rateChg = rate != rateQ;
  assign sampleTick = (sampleCnt == '0) && !rateChg;
  assign bitTick = sampleTick && (subCnt == SubW'(uartPkg::Oversample - 1));

  always_ff @(posedge clk or negedge nReset) begin
    if (!nReset) begin
      rateQ <= uartPkg::DefaultRate;
      sampleCnt <= uartPkg::RateW'(uartPkg::DefaultRate / uartPkg::Oversample - 1);
      subCnt <= '0;
    end else begin
      rateQ <= rate;
      if (rateChg) begin
        sampleCnt <= reload; // restart both dividers
        subCnt <= '0;
      end else if (sampleTick) begin
        sampleCnt <= reload;
        subCnt <= subCnt + 1'b1; // wraps every 16 samples
      end else begin
        sampleCnt <= sampleCnt - 1'b1;
      end
    end
  end

  // bit tick rides a sample tick and is never back to back
  assert property (@(posedge clk) disable iff (!nReset)
    bitTick |-> sampleTick ##1 !bitTick);

endmodule

// File: design/regBlock.sv
////////////////////
// Register block
// bus decode, config, status and FIFO strobes
////////////////////
`timescale 1ns/1ps

module regBlock (
  input  logic                      clk,
  input  logic                      nReset,
  input  uartPkg::busReqT           req,
  output uartPkg::busRspT           rsp,
  input  logic                      rxValid,
  input  uartPkg::byteT             rxData,
  output logic                      rxPop,
  input  uartPkg::fifoStatT         rxStat,
  input  logic                      rxDropped,
  input  logic                      frameErr,
  output logic                      txPush,
  output uartPkg::byteT             txData,
  input  uartPkg::fifoStatT         txStat,
  input  logic                      txIdle,
  output logic [uartPkg::RateW-1:0] rate,
  output logic                      flowCtl,
  output logic                      clear
);
  logic [31:0] rdataQ, rdataNext;
  logic [31:0] rxWord, txWord;
  logic frameErrQ, overrunQ;
  logic clearNext, rateWr, flowWr, rxStateRd;

  assign rxPop = req.ren && req.addr == uartPkg::AddrRxData;  // head leaves on read
  assign txPush = req.wen && req.addr == uartPkg::AddrTxData; // dropped by FIFO if full
  assign txData = req.wdata[$bits(uartPkg::byteT)-1:0];
  assign rateWr = req.wen && req.addr == uartPkg::AddrBaudRate;
  assign flowWr = req.wen && req.addr == uartPkg::AddrFlowCtl;
  assign rxStateRd = req.ren && req.addr == uartPkg::AddrRxState;
  assign clearNext = req.wen && req.addr == uartPkg::AddrBufClear && |req.wdata;

  // status words
  assign rxWord = 32'({frameErrQ, !rxStat.empty, rxStat.count});
  assign txWord = 32'({rate, txIdle, txStat.count}); // rate lands in [20:5]

  always_comb begin
    rdataNext = '0; // bus reads zero when not answering
    if (req.ren) begin
      case (req.addr)
        uartPkg::AddrRxData:  rdataNext = rxValid ? 32'(rxData) : '0;
        uartPkg::AddrRxState: rdataNext = rxWord;
        uartPkg::AddrTxState: rdataNext = txWord;
        default:              rdataNext = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge nReset) begin
    if (!nReset) begin
      rate <= uartPkg::DefaultRate;
      flowCtl <= 1'b1;  // flow control on
      clear <= 1'b0;
      frameErrQ <= 1'b0;
      overrunQ <= 1'b0;
      rdataQ <= '0;
    end else begin
      rdataQ <= rdataNext;
      clear <= clearNext; // one cycle pulse
      if (rateWr) rate <= req.wdata[uartPkg::RateW-1:0];
      if (flowWr) flowCtl <= |req.wdata;
      if (frameErr) frameErrQ <= 1'b1;       // new error wins over the read
      else if (rxStateRd) frameErrQ <= 1'b0; // clear on status read
      if (clear) overrunQ <= 1'b0;
      else if (rxDropped) overrunQ <= 1'b1;
    end
  end

  assign rsp = '{rdata: rdataQ, error: overrunQ};

  // bus master never reads and writes at once
  assert property (@(posedge clk) disable iff (!nReset) !(req.wen && req.ren));

endmodule

// File: design/syncFifo.sv
////////////////////
// Byte FIFO, valid/ready on both sides
// with clear and occupancy count
////////////////////
`timescale 1ns/1ps

module syncFifo (
  input  logic              clk,
  input  logic              nReset,
  input  logic              clear,
  input  logic              inValid,
  input  uartPkg::byteT     inData,
  output logic              inReady,
  output logic              outValid,
  output uartPkg::byteT     outData,
  input  logic              outReady,
  output uartPkg::fifoStatT stat
);
  localparam int PtrW = $clog2(uartPkg::FifoDepth);

  uartPkg::byteT mem [uartPkg::FifoDepth];
  logic [PtrW-1:0] wrPtr, rdPtr;
  logic [uartPkg::CountW-1:0] count;
  logic full, empty, push, pop;

  assign full = count == uartPkg::CountW'(uartPkg::FifoDepth);
  assign empty = count == '0;
  assign inReady = !full;
  assign outValid = !empty;
  assign push = inValid && inReady;  // accepted write
  assign pop = outValid && outReady; // accepted read
  assign outData = mem[rdPtr];       // head of queue
  assign stat = '{full: full, empty: empty, count: count};

  always_ff @(posedge clk or negedge nReset) begin
    if (!nReset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else if (clear) begin
      wrPtr <= '0; // contents left as is
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= wrPtr + 1'b1; // wraps at depth
      if (pop) rdPtr <= rdPtr + 1'b1;
      count <= count + uartPkg::CountW'(push) - uartPkg::CountW'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push && !clear) mem[wrPtr] <= inData;
  end

  // full and not drained keeps the write pointer still
  assert property (@(posedge clk) disable iff (!nReset)
    (full && !pop && !clear) |=> (full && wrPtr == $past(wrPtr)));
  assert property (@(posedge clk) disable iff (!nReset)
    count <= uartPkg::CountW'(uartPkg::FifoDepth));

endmodule

// File: design/uartPeriph.sv
////////////////////
// UART peripheral top level
////////////////////
`timescale 1ns/1ps

module uartPeriph (
  input  logic            clk,
  input  logic            nReset,
  input  uartPkg::busReqT req,
  output uartPkg::busRspT rsp,
  input  logic            rx,
  output logic            tx,
  input  logic            cts,
  output logic            rts
);
  logic sampleTick, bitTick;
  logic rxValid, frameErr, rxFifoReady, rxHeadValid, rxPop, rxDropped;
  logic txPush, txHeadValid, txReady, txIdle, flowCtl, clear;
  logic [uartPkg::RateW-1:0] rate;
  uartPkg::byteT rxByte, rxHead, txByte, txHead;
  uartPkg::fifoStatT rxStat, txStat;

  assign rts = rxStat.full;                   // hold off the far end
  assign rxDropped = rxValid && !rxFifoReady; // byte lost to a full FIFO

  baudGen baudGen_i (
    .clk, .nReset, .rate, .sampleTick, .bitTick
  );

  // input side
  uartRx uartRx_i (
    .clk, .nReset, .sampleTick, .rx,
    .valid(rxValid), .data(rxByte), .frameErr
  );

  syncFifo rxFifo_i (
    .clk, .nReset, .clear,
    .inValid(rxValid), .inData(rxByte), .inReady(rxFifoReady),
    .outValid(rxHeadValid), .outData(rxHead), .outReady(rxPop),
    .stat(rxStat)
  );

  regBlock regBlock_i (
    .clk, .nReset, .req, .rsp,
    .rxValid(rxHeadValid), .rxData(rxHead), .rxPop, .rxStat, .rxDropped, .frameErr,
    .txPush, .txData(txByte), .txStat, .txIdle,
    .rate, .flowCtl, .clear
  );

  // output side, push to a full FIFO is simply not taken
  syncFifo txFifo_i (
    .clk, .nReset, .clear,
    .inValid(txPush), .inData(txByte), .inReady(),
    .outValid(txHeadValid), .outData(txHead), .outReady(txReady),
    .stat(txStat)
  );

  uartTx uartTx_i (
    .clk, .nReset, .bitTick, .cts, .flowCtl,
    .valid(txHeadValid), .data(txHead), .ready(txReady),
    .idle(txIdle), .tx
  );

endmodule

// File: design/uartPkg.sv
////////////////////
// UART peripheral shared types
// register map, sizes, bus and FIFO status structs
////////////////////
package uartPkg;

  typedef logic [7:0] byteT;  // one serial data byte

  localparam int FifoDepth = 8;   // entries per FIFO
  localparam int CountW = 4;      // holds 0..FifoDepth
  localparam int RateW = 16;      // baud rate register
  localparam int Oversample = 16; // rx samples per bit

  // clocks per bit after reset
  localparam logic [RateW-1:0] DefaultRate = 16'd5207;

  // byte offsets
  localparam logic [7:0] AddrRxData   = 8'd0;
  localparam logic [7:0] AddrTxData   = 8'd4;
  localparam logic [7:0] AddrRxState  = 8'd8;
  localparam logic [7:0] AddrTxState  = 8'd12;
  localparam logic [7:0] AddrBaudRate = 8'd16;
  localparam logic [7:0] AddrBufClear = 8'd20;
  localparam logic [7:0] AddrFlowCtl  = 8'd24;

  typedef struct packed {
    logic [7:0]  addr;
    logic        wen;
    logic        ren;
    logic [31:0] wdata;
  } busReqT;

  typedef struct packed {
    logic [31:0] rdata;  // zero except the cycle after a read
    logic        error;  // rx overrun since last clear
  } busRspT;

  typedef struct packed {
    logic              full;
    logic              empty;
    logic [CountW-1:0] count;
  } fifoStatT;

endpackage

// File: design/uartRx.sv
////////////////////
// 8N1 receiver, 16x oversampling
// flags framing errors on a low stop bit
////////////////////
`timescale 1ns/1ps

module uartRx (
  input  logic          clk,
  input  logic          nReset,
  input  logic          sampleTick,
  input  logic          rx,
  output logic          valid,
  output uartPkg::byteT data,
  output logic          frameErr
);
  localparam int SubW = $clog2(uartPkg::Oversample);
  localparam int BitW = $clog2($bits(uartPkg::byteT));
  localparam logic [SubW-1:0] MidCnt = SubW'(uartPkg::Oversample / 2 - 1);
  localparam logic [SubW-1:0] EndCnt = SubW'(uartPkg::Oversample - 1);
  localparam logic [BitW-1:0] LastBit = BitW'($bits(uartPkg::byteT) - 1);

  typedef enum logic [1:0] {Idle, Start, Data, Stop} stateT;

  stateT state;
  logic [1:0] syncQ;  // metastability chain
  logic rxS;
  logic lastSample;   // previous sample for edge detect
  logic [SubW-1:0] subCnt;
  logic [BitW-1:0] bitIdx;
  uartPkg::byteT shiftQ;

  assign rxS = syncQ[1];
  assign data = shiftQ; // stable until next frame's data bits

  always_ff @(posedge clk or negedge nReset) begin
    if (!nReset) syncQ <= 2'b11; // line idles high
    else syncQ <= {syncQ[0], rx};
  end

  always_ff @(posedge clk or negedge nReset) begin
    if (!nReset) begin
      state <= Idle;
      lastSample <= 1'b1;
      subCnt <= '0;
      bitIdx <= '0;
      valid <= 1'b0;
      frameErr <= 1'b0;
    end else begin
      valid <= 1'b0;    // single cycle pulses
      frameErr <= 1'b0;
      if (sampleTick) begin
        lastSample <= rxS;
        subCnt <= subCnt + 1'b1;
        case (state)
          Idle: if (lastSample && !rxS) begin
            state <= Start; // falling edge seen
            subCnt <= '0;
          end
          Start: if (subCnt == MidCnt) begin
            subCnt <= '0;   // realign to mid-bit
            bitIdx <= '0;
            state <= rxS ? Idle : Data; // glitch goes back
          end
          Data: if (subCnt == EndCnt) begin
            bitIdx <= bitIdx + 1'b1;
            if (bitIdx == LastBit) state <= Stop;
          end
          Stop: if (subCnt == EndCnt) begin
            valid <= rxS;
            frameErr <= !rxS; // low stop bit
            state <= Idle;
          end
          default: state <= Idle;
        endcase
      end
    end
  end

  // lsb first
  always_ff @(posedge clk) begin
    if (sampleTick && state == Data && subCnt == EndCnt) shiftQ <= {rxS, shiftQ[7:1]};
  end

  // one outcome per frame, never repeated next cycle
  assert property (@(posedge clk) disable iff (!nReset)
    (valid || frameErr) |-> !(valid && frameErr) ##1 !(valid || frameErr));

endmodule

// File: design/uartTx.sv
////////////////////
// 8N1 transmitter
// pulls bytes by valid/ready, honours cts
////////////////////
`timescale 1ns/1ps

module uartTx (
  input  logic          clk,
  input  logic          nReset,
  input  logic          bitTick,
  input  logic          cts,
  input  logic          flowCtl,
  input  logic          valid,
  input  uartPkg::byteT data,
  output logic          ready,
  output logic          idle,
  output logic          tx
);
  localparam int BitW = $clog2($bits(uartPkg::byteT));
  localparam logic [BitW-1:0] LastBit = BitW'($bits(uartPkg::byteT) - 1);

  typedef enum logic [1:0] {Idle, Start, Data, Stop} stateT;

  stateT state;
  uartPkg::byteT shiftQ;
  logic [BitW-1:0] bitIdx;
  logic ctsOk, take;

  assign ctsOk = cts || !flowCtl; // cts ignored with flow control off
  // accept only at a bit boundary, one byte per frame
  assign ready = bitTick && ctsOk && (state == Idle || state == Stop);
  assign take = valid && ready;
  assign idle = state == Idle;

  always_comb begin
    case (state)
      Start:   tx = 1'b0;
      Data:    tx = shiftQ[0];
      default: tx = 1'b1; // idle and stop
    endcase
  end

  always_ff @(posedge clk or negedge nReset) begin
    if (!nReset) begin
      state <= Idle;
      bitIdx <= '0;
    end else if (bitTick) begin
      case (state)
        Idle:  if (take) state <= Start;
        Start: begin
          state <= Data;
          bitIdx <= '0;
        end
        Data: begin
          bitIdx <= bitIdx + 1'b1;
          if (bitIdx == LastBit) state <= Stop;
        end
        default: state <= take ? Start : Idle; // back to back frames
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) shiftQ <= data;
    else if (bitTick && state == Data) shiftQ <= shiftQ >> 1;
  end

  assert property (@(posedge clk) disable iff (!nReset) idle |-> tx);

endmodule

// File: flist.f
design/uartPkg.sv
design/syncFifo.sv
design/baudGen.sv
design/uartRx.sv
design/uartTx.sv
design/regBlock.sv
design/uartPeriph.sv
sim/uartTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the UART testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module uartTb -f flist.f -o uartSim &&
  ./obj_dir/uartSim | tee /dev/stderr | grep -qx 'RESULT: PASS' &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

// File: sim/uartTb.sv
////////////////////
// UART peripheral testbench
// directed bus and serial tests
////////////////////
`timescale 1ns/1ps

module uartTb;
  localparam int TestRate = 32;
  localparam int BitClks = 16 * (TestRate / 16); // clocks per bit at the test rate

  logic clk, nReset, rx, tx, cts, rts;
  uartPkg::busReqT req;
  uartPkg::busRspT rsp;
  logic [31:0] rngState;
  int errors, checks;

  uartPeriph uartPeriph_i (.clk, .nReset, .req, .rsp, .rx, .tx, .cts, .rts);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // xorshift32
  function automatic uartPkg::byteT nextRandomByte();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState[7:0];
  endfunction

  // expected status words, bit layout of the register map
  function automatic logic [31:0] rxStateWord(input logic fe, input logic nonEmpty,
                                              input logic [3:0] cnt);
    return {26'd0, fe, nonEmpty, cnt};
  endfunction

  function automatic logic [31:0] txStateWord(input logic [15:0] r, input logic idleBit,
                                              input logic [3:0] cnt);
    return {11'd0, r, idleBit, cnt};
  endfunction

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED t=%0t %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic timeoutFail(input string what);
    $display("timeout at t=%0t: %s", $time, what);
    errors++;
  endtask

  task automatic finishTest(input string name, input int errsBefore);
    if (errors == errsBefore) $display("test %s: ok", name);
    else $display("test %s: %0d error(s)", name, errors - errsBefore);
  endtask

  // one request cycle, driven on the falling edge
  task automatic busWrite(input logic [7:0] addr, input logic [31:0] data);
    req = '{addr: addr, wen: 1'b1, ren: 1'b0, wdata: data};
    @(negedge clk);
    req = '0;
  endtask

  task automatic busRead(input logic [7:0] addr, output logic [31:0] data);
    req = '{addr: addr, wen: 1'b0, ren: 1'b1, wdata: '0};
    @(negedge clk);    // rising edge in between took the request
    req = '0;
    data = rsp.rdata;  // answer holds for this one cycle
  endtask

  task automatic serialSend(input uartPkg::byteT b, input logic stopBit);
    rx = 1'b0; // start bit
    repeat (BitClks) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      rx = b[i]; // lsb first
      repeat (BitClks) @(negedge clk);
    end
    rx = stopBit;
    repeat (BitClks) @(negedge clk);
    rx = 1'b1;
    if (!stopBit) repeat (BitClks) @(negedge clk); // idle gap after a bad frame
  endtask

  task automatic serialCapture(output uartPkg::byteT b);
    int n;
    b = '0;
    for (n = 0; n < 40 * BitClks && tx; n++) @(negedge clk);
    if (tx) begin
      timeoutFail("no start bit on tx");
      return;
    end
    repeat (BitClks / 2) @(negedge clk); // middle of start bit
    checkEq("tx start bit", 32'(tx), 0);
    for (int i = 0; i < 8; i++) begin
      repeat (BitClks) @(negedge clk);
      b[i] = tx;
    end
    repeat (BitClks) @(negedge clk);
    checkEq("tx stop bit", 32'(tx), 1);
  endtask

  task automatic testResetState();
    int e0;
    logic [31:0] d;
    e0 = errors;
    checkEq("tx", 32'(tx), 1);
    checkEq("rts", 32'(rts), 0);
    checkEq("rsp.error", 32'(rsp.error), 0);
    checkEq("rsp.rdata", rsp.rdata, 0);
    busRead(uartPkg::AddrTxState, d);
    checkEq("tx status", d, txStateWord(16'd5207, 1'b1, 4'd0));
    busRead(uartPkg::AddrRxState, d);
    checkEq("rx status", d, 0);
    finishTest("reset state", e0);
  endtask

  task automatic testTransmit();
    int e0;
    uartPkg::byteT sent[$];
    uartPkg::byteT b;
    e0 = errors;
    busWrite(uartPkg::AddrBaudRate, TestRate);
    busWrite(uartPkg::AddrFlowCtl, 0);
    for (int i = 0; i < 4; i++) begin
      b = nextRandomByte();
      sent.push_back(b);
      busWrite(uartPkg::AddrTxData, 32'(b));
    end
    foreach (sent[i]) begin
      serialCapture(b); // frames come out in write order
      checkEq($sformatf("tx frame %0d", i), 32'(b), 32'(sent[i]));
    end
    finishTest("transmit", e0);
  endtask

  task automatic testReceive();
    int e0, n;
    uartPkg::byteT sent[$];
    uartPkg::byteT b;
    logic [31:0] d;
    e0 = errors;
    for (int i = 0; i < 5; i++) begin
      b = nextRandomByte();
      sent.push_back(b);
      serialSend(b, 1'b1);
    end
    d = '0;
    for (n = 0; n < 50 && d[3:0] != 4'd5; n++) busRead(uartPkg::AddrRxState, d);
    if (d[3:0] != 4'd5) timeoutFail("rx count did not reach 5");
    checkEq("rx status", d, rxStateWord(1'b0, 1'b1, 4'd5));
    foreach (sent[i]) begin
      busRead(uartPkg::AddrRxData, d);
      checkEq($sformatf("rx data %0d", i), d, 32'(sent[i]));
    end
    busRead(uartPkg::AddrRxState, d);
    checkEq("rx count", 32'(d[3:0]), 0);
    finishTest("receive", e0);
  endtask

  task automatic testFlowControl();
    int e0;
    uartPkg::byteT b, got;
    logic quiet;
    e0 = errors;
    cts = 1'b0; // far end not ready
    busWrite(uartPkg::AddrFlowCtl, 1);
    b = nextRandomByte();
    busWrite(uartPkg::AddrTxData, 32'(b));
    quiet = 1'b1;
    repeat (30 * BitClks) begin // three frame times
      @(negedge clk);
      if (!tx) quiet = 1'b0;
    end
    checkEq("tx held by cts", 32'(quiet), 1);
    cts = 1'b1;
    serialCapture(got);
    checkEq("tx frame after cts", 32'(got), 32'(b));
    finishTest("flow control", e0);
  endtask

  task automatic testOverrunClear();
    int e0, n;
    logic [31:0] d;
    e0 = errors;
    for (int i = 0; i < 8; i++) serialSend(nextRandomByte(), 1'b1);
    for (n = 0; n < 4 * BitClks && !rts; n++) @(negedge clk);
    if (!rts) timeoutFail("rts did not rise with the rx FIFO full");
    checkEq("rts", 32'(rts), 1);       // rx FIFO full
    checkEq("rsp.error", 32'(rsp.error), 0);
    serialSend(nextRandomByte(), 1'b1); // ninth byte has nowhere to go
    for (n = 0; n < 4 * BitClks && !rsp.error; n++) @(negedge clk);
    if (!rsp.error) timeoutFail("overrun error did not rise");
    checkEq("rsp.error", 32'(rsp.error), 1);
    cts = 1'b0; // park two bytes in the tx FIFO
    busWrite(uartPkg::AddrTxData, 32'(nextRandomByte()));
    busWrite(uartPkg::AddrTxData, 32'(nextRandomByte()));
    busRead(uartPkg::AddrTxState, d);
    checkEq("tx status before clear", d, txStateWord(16'(TestRate), 1'b1, 4'd2));
    busWrite(uartPkg::AddrBufClear, 1);
    @(negedge clk); // FIFOs empty one cycle after the write
    checkEq("rts after clear", 32'(rts), 0);
    checkEq("rsp.error after clear", 32'(rsp.error), 0);
    busRead(uartPkg::AddrRxState, d);
    checkEq("rx status after clear", d, 0);
    busRead(uartPkg::AddrTxState, d);
    checkEq("tx status after clear", d, txStateWord(16'(TestRate), 1'b1, 4'd0));
    cts = 1'b1;
    finishTest("overrun and clear", e0);
  endtask

  task automatic testFramingError();
    int e0;
    logic [31:0] d;
    e0 = errors;
    serialSend(nextRandomByte(), 1'b0); // low stop bit
    busRead(uartPkg::AddrRxState, d);
    checkEq("rx status framing", d, rxStateWord(1'b1, 1'b0, 4'd0));
    busRead(uartPkg::AddrRxState, d); // sticky bit gone after the first read
    checkEq("rx status reread", d, 0);
    finishTest("framing error", e0);
  endtask

  initial begin
    nReset = 1'b0;
    req = '0;
    rx = 1'b1;  // idle line
    cts = 1'b1;
    rngState = 32'd54;
    errors = 0;
    checks = 0;
    repeat (10) @(negedge clk);
    nReset = 1'b1;
    @(negedge clk);
    testResetState();
    testTransmit();
    testReceive();
    testFlowControl();
    testOverrunClear();
    testFramingError();
    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
